// ==== logic/aes_settings.svh ====
`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

// AXI4-Lite bus
`define AXI_ADDR_W 12
`define AXI_DATA_W 32

// key schedule widths
`define WORD_S 32
`define BYTE_S 8
`define ROUND_KEY_BITS 128
`define KEY_S 256
`define ROUND_IDX_W 4

// round counts, rounds plus one keys per run
`define MAX_ROUND_KEYS 15
`define ROUNDS_AES128 10
`define ROUNDS_AES256 14

// register map, word 0 is the most significant
`define REG_KEY_BASE 12'h000
`define REG_CTRL 12'h020
`define REG_STATUS 12'h024
`define REG_RK_BASE 12'h100

`endif

// ==== logic/aes_pkg.sv ====
`default_nettype none

`include "aes_settings.svh"

package aes_pkg;

	typedef logic [`BYTE_S-1:0] byte_t;
	typedef logic [`WORD_S-1:0] word_t;
	typedef logic [`ROUND_KEY_BITS-1:0] round_key_t;
	typedef logic [`KEY_S-1:0] cipher_key_t;
	typedef logic [`ROUND_IDX_W-1:0] round_idx_t;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		EXPAND,
		DONE
	} fsm_state_t;

	// forward s-box, one row of 16 entries per line, entry 0 at the top
	localparam logic [2047:0] SBOX_TABLE = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	function automatic byte_t sbox(input byte_t b);
		// entry b sits at bit (255 - b) * 8
		return SBOX_TABLE[{~b, 3'b000} +: `BYTE_S];
	endfunction

	function automatic word_t sub_word(input word_t w);
		word_t r;
		for (int i = 0; i < `WORD_S / `BYTE_S; i++) begin
			r[i*`BYTE_S +: `BYTE_S] = sbox(w[i*`BYTE_S +: `BYTE_S]);
		end
		return r;
	endfunction

	function automatic word_t rot_word(input word_t w);
		return {w[`WORD_S-`BYTE_S-1:0], w[`WORD_S-1 -: `BYTE_S]};
	endfunction

	function automatic byte_t rcon_of(input round_idx_t idx);
		case (idx)
			4'd0: return 8'h01;
			4'd1: return 8'h02;
			4'd2: return 8'h04;
			4'd3: return 8'h08;
			4'd4: return 8'h10;
			4'd5: return 8'h20;
			4'd6: return 8'h40;
			4'd7: return 8'h80;
			4'd8: return 8'h1b;
			4'd9: return 8'h36;
			default: return 8'h00;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== logic/key_sched_fsm.sv ====
`default_nettype none

module key_sched_fsm
	import aes_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic last_round,
	output logic count_en,
	output logic load,
	output logic busy,
	output logic done
);

	fsm_state_t state;
	fsm_state_t state_next;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (start) begin
					state_next = LOAD;
				end
			end
			LOAD: begin
				state_next = EXPAND;
			end
			EXPAND: begin
				if (last_round) begin
					state_next = DONE;
				end
			end
			DONE: begin
				// a new start reruns with whatever key is loaded now
				if (start) begin
					state_next = LOAD;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	// one store write per cycle in LOAD and EXPAND
	assign count_en = (state == LOAD) || (state == EXPAND);
	assign load = (state == LOAD);
	assign busy = (state == LOAD) || (state == EXPAND);
	assign done = (state == DONE);

endmodule

`default_nettype wire

// ==== logic/round_counter.sv ====
`default_nettype none

`include "aes_settings.svh"

module round_counter
	import aes_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       count_en,
	input  logic       aes256_mode,
	output round_idx_t round_no,
	output logic       last_round
);

	round_idx_t final_round;

	assign final_round = aes256_mode ? round_idx_t'(`ROUNDS_AES256)
		: round_idx_t'(`ROUNDS_AES128);

	assign last_round = (round_no == final_round);

	always_ff @(posedge clk) begin
		if (reset) begin
			round_no <= '0;
		end else if (count_en) begin
			// wrap to zero, ready for the next run
			if (last_round) begin
				round_no <= '0;
			end else begin
				round_no <= round_no + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/key_expand_core.sv ====
`default_nettype none

`include "aes_settings.svh"

module key_expand_core
	import aes_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        count_en,
	input  logic        load,
	input  logic        aes256_mode,
	input  cipher_key_t key,
	input  round_idx_t  round_no,
	output round_key_t  next_key,
	output logic        key_we,
	output round_idx_t  key_addr
);

	localparam int WORDS = `ROUND_KEY_BITS / `WORD_S;

	logic       mode_q;
	round_key_t key_lo_q;
	// older round key in the upper half, newest in the lower half
	logic [2*`ROUND_KEY_BITS-1:0] hist;

	round_key_t base_key;
	round_key_t schedule;
	word_t      g_src;
	word_t      g;
	round_idx_t rcon_idx;
	logic       rot_step;

	always_ff @(posedge clk) begin
		if (reset) begin
			mode_q <= 1'b0;
		end else if (load) begin
			mode_q <= aes256_mode;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			key_lo_q <= key[`ROUND_KEY_BITS-1:0];
		end
		if (count_en) begin
			hist <= {hist[`ROUND_KEY_BITS-1:0], next_key};
		end
	end

	// AES-256 chains from two keys back, AES-128 from the last one
	assign base_key = mode_q ? hist[2*`ROUND_KEY_BITS-1 -: `ROUND_KEY_BITS]
		: hist[`ROUND_KEY_BITS-1:0];
	assign g_src = hist[`WORD_S-1:0];

	assign rot_step = !mode_q || !round_no[0];
	assign rcon_idx = mode_q ? (round_no >> 1) - 1'b1 : round_no - 1'b1;

	always_comb begin
		if (rot_step) begin
			g = sub_word(rot_word(g_src));
			g[`WORD_S-1 -: `BYTE_S] = g[`WORD_S-1 -: `BYTE_S] ^ rcon_of(rcon_idx);
		end else begin
			g = sub_word(g_src);
		end

		schedule[`ROUND_KEY_BITS-1 -: `WORD_S] =
			g ^ base_key[`ROUND_KEY_BITS-1 -: `WORD_S];
		for (int i = 1; i < WORDS; i++) begin
			schedule[`ROUND_KEY_BITS-1-i*`WORD_S -: `WORD_S] =
				schedule[`ROUND_KEY_BITS-1-(i-1)*`WORD_S -: `WORD_S]
				^ base_key[`ROUND_KEY_BITS-1-i*`WORD_S -: `WORD_S];
		end
	end

	always_comb begin
		if (round_no == '0) begin
			// straight from the key register during LOAD
			next_key = key[`KEY_S-1 -: `ROUND_KEY_BITS];
		end else if (mode_q && round_no == round_idx_t'(1)) begin
			next_key = key_lo_q;
		end else begin
			next_key = schedule;
		end
	end

	assign key_we = count_en;
	assign key_addr = round_no;

endmodule

`default_nettype wire

// ==== logic/round_key_store.sv ====
`default_nettype none

`include "aes_settings.svh"

module round_key_store
	import aes_pkg::*;
(
	input  logic       clk,
	input  logic       we,
	input  round_idx_t wr_addr,
	input  round_key_t wr_data,
	input  round_idx_t rd_addr,
	input  logic [1:0] rd_word,
	output word_t      rd_data
);

	round_key_t mem [`MAX_ROUND_KEYS];
	round_key_t rd_key;

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_addr] <= wr_data;
		end
	end

	always_comb begin
		if (rd_addr < round_idx_t'(`MAX_ROUND_KEYS)) begin
			rd_key = mem[rd_addr];
		end else begin
			rd_key = '0;
		end
	end

	// word 0 is the top 32 bits of the key
	assign rd_data = rd_key[`ROUND_KEY_BITS-1-rd_word*`WORD_S -: `WORD_S];

endmodule

`default_nettype wire

// ==== logic/axil_key_regs.sv ====
`default_nettype none

`include "aes_settings.svh"

module axil_key_regs
	import aes_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic [`AXI_ADDR_W-1:0]    awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	input  logic [`AXI_DATA_W-1:0]    wdata,
	input  logic [`AXI_DATA_W/8-1:0]  wstrb,
	input  logic                      wvalid,
	output logic                      wready,
	output logic [1:0]                bresp,
	output logic                      bvalid,
	input  logic                      bready,
	input  logic [`AXI_ADDR_W-1:0]    araddr,
	input  logic                      arvalid,
	output logic                      arready,
	output logic [`AXI_DATA_W-1:0]    rdata,
	output logic [1:0]                rresp,
	output logic                      rvalid,
	input  logic                      rready,
	input  logic                      busy,
	input  logic                      done,
	input  word_t                     rd_data,
	output logic                      start,
	output logic                      aes256_mode,
	output cipher_key_t               key,
	output round_idx_t                rd_addr,
	output logic [1:0]                rd_word
);

	localparam int KEY_WORDS = `KEY_S / `WORD_S;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	localparam logic [`AXI_ADDR_W-1:0] RK_BASE = `REG_RK_BASE;
	localparam logic [`AXI_ADDR_W-1:0] KEY_BASE = `REG_KEY_BASE;

	word_t key_words [KEY_WORDS];

	logic wr_fire;
	logic rd_fire;
	logic [`AXI_DATA_W-1:0] rd_value;
	logic [1:0] rd_resp;
	round_idx_t rk_last;

	assign wr_fire = awvalid && awready && wvalid && wready;
	assign rd_fire = arvalid && arready;

	always_comb begin
		for (int i = 0; i < KEY_WORDS; i++) begin
			key[`KEY_S-1-i*`WORD_S -: `WORD_S] = key_words[i];
		end
	end

	// write side, both channels accepted together
	always_ff @(posedge clk) begin
		if (reset) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			start <= 1'b0;
			aes256_mode <= 1'b0;
			for (int i = 0; i < KEY_WORDS; i++) begin
				key_words[i] <= '0;
			end
		end else begin
			awready <= 1'b0;
			wready <= 1'b0;
			start <= 1'b0;
			if (awvalid && wvalid && !awready && !bvalid) begin
				awready <= 1'b1;
				wready <= 1'b1;
			end
			if (wr_fire) begin
				bvalid <= 1'b1;
				if (awaddr[`AXI_ADDR_W-1:5] == KEY_BASE[`AXI_ADDR_W-1:5]) begin
					for (int b = 0; b < `AXI_DATA_W / 8; b++) begin
						if (wstrb[b]) begin
							key_words[awaddr[4:2]][b*8 +: 8] <= wdata[b*8 +: 8];
						end
					end
				end else if (awaddr == `REG_CTRL && wstrb[0]) begin
					aes256_mode <= wdata[1];
					start <= wdata[0];
				end
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	assign bresp = RESP_OKAY;

	// round-key lookup straight off the read address
	assign rd_addr = araddr[7:4];
	assign rd_word = araddr[3:2];
	assign rk_last = aes256_mode ? round_idx_t'(`ROUNDS_AES256)
		: round_idx_t'(`ROUNDS_AES128);

	always_comb begin
		rd_value = '0;
		rd_resp = RESP_SLVERR;
		if (araddr[`AXI_ADDR_W-1:5] == KEY_BASE[`AXI_ADDR_W-1:5]) begin
			rd_value = key_words[araddr[4:2]];
			rd_resp = RESP_OKAY;
		end else if (araddr == `REG_CTRL) begin
			rd_value = {{(`AXI_DATA_W-2){1'b0}}, aes256_mode, 1'b0};
			rd_resp = RESP_OKAY;
		end else if (araddr == `REG_STATUS) begin
			rd_value = {{(`AXI_DATA_W-2){1'b0}}, done, busy};
			rd_resp = RESP_OKAY;
		end else if (araddr[`AXI_ADDR_W-1:8] == RK_BASE[`AXI_ADDR_W-1:8]
			&& rd_addr <= rk_last) begin
			rd_value = rd_data;
			rd_resp = RESP_OKAY;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= 1'b0;
			if (arvalid && !arready && !rvalid) begin
				arready <= 1'b1;
			end
			if (rd_fire) begin
				rvalid <= 1'b1;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rdata <= rd_value;
			rresp <= rd_resp;
		end
	end

endmodule

`default_nettype wire

// ==== logic/key_expansion_top.sv ====
`default_nettype none

`include "aes_settings.svh"

module key_expansion_top
	import aes_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic [`AXI_ADDR_W-1:0]    awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	input  logic [`AXI_DATA_W-1:0]    wdata,
	input  logic [`AXI_DATA_W/8-1:0]  wstrb,
	input  logic                      wvalid,
	output logic                      wready,
	output logic [1:0]                bresp,
	output logic                      bvalid,
	input  logic                      bready,
	input  logic [`AXI_ADDR_W-1:0]    araddr,
	input  logic                      arvalid,
	output logic                      arready,
	output logic [`AXI_DATA_W-1:0]    rdata,
	output logic [1:0]                rresp,
	output logic                      rvalid,
	input  logic                      rready
);

	logic        start;
	logic        aes256_mode;
	cipher_key_t key;
	logic        busy;
	logic        done;
	logic        count_en;
	logic        load;
	round_idx_t  round_no;
	logic        last_round;
	round_key_t  next_key;
	logic        key_we;
	round_idx_t  key_addr;
	round_idx_t  rd_addr;
	logic [1:0]  rd_word;
	word_t       rd_data;

	axil_key_regs u_regs (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.busy(busy),
		.done(done),
		.rd_data(rd_data),
		.start(start),
		.aes256_mode(aes256_mode),
		.key(key),
		.rd_addr(rd_addr),
		.rd_word(rd_word)
	);

	key_sched_fsm u_fsm (
		.clk(clk),
		.reset(reset),
		.start(start),
		.last_round(last_round),
		.count_en(count_en),
		.load(load),
		.busy(busy),
		.done(done)
	);

	round_counter u_counter (
		.clk(clk),
		.reset(reset),
		.count_en(count_en),
		.aes256_mode(aes256_mode),
		.round_no(round_no),
		.last_round(last_round)
	);

	key_expand_core u_core (
		.clk(clk),
		.reset(reset),
		.count_en(count_en),
		.load(load),
		.aes256_mode(aes256_mode),
		.key(key),
		.round_no(round_no),
		.next_key(next_key),
		.key_we(key_we),
		.key_addr(key_addr)
	);

	round_key_store u_store (
		.clk(clk),
		.we(key_we),
		.wr_addr(key_addr),
		.wr_data(next_key),
		.rd_addr(rd_addr),
		.rd_word(rd_word),
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

// ==== verif/key_expansion_checker.sv ====
`default_nettype none

`include "aes_settings.svh"

module key_expansion_checker
	import aes_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   bvalid,
	input  logic                   bready,
	input  logic [1:0]             bresp,
	input  logic                   rvalid,
	input  logic                   rready,
	input  word_t                  rdata,
	input  logic [1:0]             rresp,
	input  logic                   exp_active,
	input  logic [8*16-1:0]        exp_name,
	input  logic [`AXI_ADDR_W-1:0] exp_addr,
	input  word_t                  exp_data,
	input  logic [1:0]             exp_resp,
	output int                     pass_count,
	output int                     fail_count
);

	localparam logic [1:0] RESP_OKAY = 2'b00;

	// response seen last cycle without rready
	logic  held;
	word_t held_data;

	always @(posedge clk) begin
		if (reset) begin
			pass_count <= 0;
			fail_count <= 0;
			held <= 1'b0;
			held_data <= '0;
		end else begin
			if (bvalid && bready && bresp !== RESP_OKAY) begin
				$display("CHECK FAILED %0s write response expected %0d actual %0d",
					exp_name, RESP_OKAY, bresp);
				fail_count <= fail_count + 1;
			end else if (held && rvalid && rdata !== held_data) begin
				$display("ERROR: read data changed while the response was stalled");
				fail_count <= fail_count + 1;
			end else if (rvalid && rready && exp_active) begin
				if (rdata === exp_data && rresp === exp_resp) begin
					$display("ok %0s addr %h data %h resp %0d",
						exp_name, exp_addr, rdata, rresp);
					pass_count <= pass_count + 1;
				end else begin
					$display("CHECK FAILED %0s addr %h expected %h resp %0d actual %h resp %0d",
						exp_name, exp_addr, exp_data, exp_resp, rdata, rresp);
					fail_count <= fail_count + 1;
				end
			end
			held <= rvalid && !rready;
			held_data <= rdata;
		end
	end

endmodule

`default_nettype wire

// ==== verif/key_expansion_tb.sv ====
`default_nettype none

`include "aes_settings.svh"

module key_expansion_tb
	import aes_pkg::*;
();

	typedef logic [`AXI_ADDR_W-1:0] addr_t;
	typedef logic [8*16-1:0] name_t;

	typedef struct packed {
		name_t      name;
		logic       aes256;
		logic [1:0] disturb;
		logic       stall;
	} run_t;

	localparam int TIMEOUT = 64;
	localparam int POLL_MAX = 40;
	localparam logic [1:0] OKAY = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;
	localparam logic [1:0] DIST_NONE = 2'd0;
	localparam logic [1:0] DIST_RESTART = 2'd1;
	localparam logic [1:0] DIST_REKEY = 2'd2;

	// FIPS-197 appendix A keys and schedules, round 0 first
	localparam logic [127:0] KEY128 = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam logic [255:0] KEY256 =
		256'h603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4;

	localparam logic [11*`ROUND_KEY_BITS-1:0] RK128 = {
		128'h2b7e151628aed2a6abf7158809cf4f3c,
		128'ha0fafe1788542cb123a339392a6c7605,
		128'hf2c295f27a96b9435935807a7359f67f,
		128'h3d80477d4716fe3e1e237e446d7a883b,
		128'hef44a541a8525b7fb671253bdb0bad00,
		128'hd4d1c6f87c839d87caf2b8bc11f915bc,
		128'h6d88a37a110b3efddbf98641ca0093fd,
		128'h4e54f70e5f5fc9f384a64fb24ea6dc4f,
		128'head27321b58dbad2312bf5607f8d292f,
		128'hac7766f319fadc2128d12941575c006e,
		128'hd014f9a8c9ee2589e13f0cc8b6630ca6
	};

	localparam logic [15*`ROUND_KEY_BITS-1:0] RK256 = {
		128'h603deb1015ca71be2b73aef0857d7781,
		128'h1f352c073b6108d72d9810a30914dff4,
		128'h9ba354118e6925afa51a8b5f2067fcde,
		128'ha8b09c1a93d194cdbe49846eb75d5b9a,
		128'hd59aecb85bf3c917fee94248de8ebe96,
		128'hb5a9328a2678a647983122292f6c79b3,
		128'h812c81addadf48ba24360af2fab8b464,
		128'h98c5bfc9bebd198e268c3ba709e04214,
		128'h68007bacb2df331696e939e46c518d80,
		128'hc814e20476a9fb8a5025c02d59c58239,
		128'hde1369676ccc5a71fa2563959674ee15,
		128'h5886ca5d2e2f31d77e0af1fa27cf73c3,
		128'h749c47ab18501ddae2757e4f7401905a,
		128'hcafaaae3e4d59b349adf6acebd10190d,
		128'hfe4890d1e6188d0b046df344706c631e
	};

	logic clk;
	logic reset;
	addr_t awaddr;
	logic awvalid;
	logic awready;
	logic [`AXI_DATA_W-1:0] wdata;
	logic [`AXI_DATA_W/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	addr_t araddr;
	logic arvalid;
	logic arready;
	logic [`AXI_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	logic exp_active;
	name_t exp_name;
	addr_t exp_addr;
	word_t exp_data;
	logic [1:0] exp_resp;
	int pass_count;
	int fail_count;

	int seed;
	logic stall_on;
	run_t runs [5];

	key_expansion_top uut (.*);

	key_expansion_checker chk (
		.clk(clk),
		.reset(reset),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp),
		.exp_active(exp_active),
		.exp_name(exp_name),
		.exp_addr(exp_addr),
		.exp_data(exp_data),
		.exp_resp(exp_resp),
		.pass_count(pass_count),
		.fail_count(fail_count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string what);
		$display("ERROR: %s", what);
		$display("sim failed");
		$finish;
	endtask

	task automatic random_stall();
		int n;
		n = stall_on ? {$random(seed)} % 4 : 0;
		repeat (n) @(posedge clk);
	endtask

	task automatic write_reg(input addr_t addr, input word_t data, input logic [3:0] strb);
		int cnt;
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wstrb <= strb;
		wvalid <= 1'b1;
		cnt = 0;
		do begin
			@(posedge clk);
			cnt++;
			if (cnt > TIMEOUT) begin
				abort_run("write address and data were never accepted");
			end
		end while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		random_stall();
		bready <= 1'b1;
		cnt = 0;
		do begin
			@(posedge clk);
			cnt++;
			if (cnt > TIMEOUT) begin
				abort_run("write response never arrived");
			end
		end while (!bvalid);
		bready <= 1'b0;
	endtask

	task automatic read_reg(input addr_t addr, output word_t data);
		int cnt;
		araddr <= addr;
		arvalid <= 1'b1;
		cnt = 0;
		do begin
			@(posedge clk);
			cnt++;
			if (cnt > TIMEOUT) begin
				abort_run("read address was never accepted");
			end
		end while (!arready);
		arvalid <= 1'b0;
		random_stall();
		rready <= 1'b1;
		cnt = 0;
		do begin
			@(posedge clk);
			cnt++;
			if (cnt > TIMEOUT) begin
				abort_run("read data never arrived");
			end
		end while (!rvalid);
		data = rdata;
		rready <= 1'b0;
	endtask

	// the checker compares at the read handshake
	task automatic expect_reg(input name_t name, input addr_t addr, input word_t data,
		input logic [1:0] resp);
		word_t unused;
		exp_active <= 1'b1;
		exp_name <= name;
		exp_addr <= addr;
		exp_data <= data;
		exp_resp <= resp;
		read_reg(addr, unused);
		exp_active <= 1'b0;
	endtask

	task automatic wait_for_done();
		word_t status;
		int polls;
		status = '0;
		polls = 0;
		while (!status[1]) begin
			if (polls == POLL_MAX) begin
				abort_run("done never showed up in the status register");
			end
			read_reg(`REG_STATUS, status);
			polls++;
		end
	endtask

	function automatic round_key_t expected_key(input logic aes256, input int n);
		if (aes256) begin
			return RK256[(14 - n) * `ROUND_KEY_BITS +: `ROUND_KEY_BITS];
		end
		return RK128[(10 - n) * `ROUND_KEY_BITS +: `ROUND_KEY_BITS];
	endfunction

	task automatic verify_schedule(input name_t name, input logic aes256);
		int last;
		round_key_t rk;
		last = aes256 ? `ROUNDS_AES256 : `ROUNDS_AES128;
		for (int n = 0; n <= last; n++) begin
			rk = expected_key(aes256, n);
			for (int w = 0; w < 4; w++) begin
				expect_reg(name, addr_t'(`REG_RK_BASE + 16 * n + 4 * w),
					rk[`ROUND_KEY_BITS-1-`WORD_S*w -: `WORD_S], OKAY);
			end
		end
		// one past the last key of the mode
		expect_reg(name, addr_t'(`REG_RK_BASE + 16 * (last + 1)), '0, SLVERR);
	endtask

	task automatic run_expansion(input run_t run);
		cipher_key_t key;
		word_t ctrl;
		exp_name <= run.name;
		key = run.aes256 ? KEY256 : {KEY128, 128'h0};
		ctrl = {30'd0, run.aes256, 1'b1};
		for (int i = 0; i < 8; i++) begin
			write_reg(addr_t'(`REG_KEY_BASE + 4 * i), key[`KEY_S-1-`WORD_S*i -: `WORD_S], 4'hf);
		end
		write_reg(`REG_CTRL, ctrl, 4'h1);
		expect_reg(run.name, `REG_STATUS, 32'h1, OKAY);
		if (run.disturb == DIST_RESTART) begin
			// a restart that is not ignored would pick up this key
			write_reg(`REG_KEY_BASE, ~key[`KEY_S-1 -: `WORD_S], 4'hf);
			write_reg(`REG_CTRL, ctrl, 4'h1);
		end else if (run.disturb == DIST_REKEY) begin
			write_reg(`REG_KEY_BASE, ~key[`KEY_S-1 -: `WORD_S], 4'hf);
			write_reg(addr_t'(`REG_KEY_BASE + 28), ~key[`WORD_S-1:0], 4'hf);
		end
		wait_for_done();
		expect_reg(run.name, `REG_STATUS, 32'h2, OKAY);
		verify_schedule(run.name, run.aes256);
	endtask

	initial begin
		seed = 32'h568947f2;
		stall_on = 1'b0;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		exp_active = 1'b0;
		exp_name = '0;
		exp_addr = '0;
		exp_data = '0;
		exp_resp = '0;

		// name, aes256, disturbance during the run, random stalls
		runs[0] = '{"aes128", 1'b0, DIST_NONE, 1'b0};
		runs[1] = '{"aes256", 1'b1, DIST_NONE, 1'b0};
		runs[2] = '{"aes128 restart", 1'b0, DIST_RESTART, 1'b0};
		runs[3] = '{"aes256 rekey", 1'b1, DIST_REKEY, 1'b0};
		runs[4] = '{"aes128 stalled", 1'b0, DIST_NONE, 1'b1};

		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		expect_reg("reset status", `REG_STATUS, '0, OKAY);
		expect_reg("reset key", `REG_KEY_BASE, '0, OKAY);
		foreach (runs[i]) begin
			stall_on = runs[i].stall;
			run_expansion(runs[i]);
		end
		expect_reg("unmapped", addr_t'(12'h040), '0, SLVERR);

		repeat (2) @(posedge clk);
		$display("%0d checks passed, %0d checks failed", pass_count, fail_count);
		if (fail_count == 0 && pass_count > 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+logic
logic/aes_pkg.sv
logic/key_sched_fsm.sv
logic/round_counter.sv
logic/key_expand_core.sv
logic/round_key_store.sv
logic/axil_key_regs.sv
logic/key_expansion_top.sv
verif/key_expansion_checker.sv
verif/key_expansion_tb.sv

// ==== Makefile ====
# Verilator build and run of the key expansion testbench

VERILATOR ?= verilator
TOP ?= key_expansion_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
